// File: cart/cart_header_sniffer.sv
//////////////////////////////
// rom stream header sniffer: game id,
// region letters, core hold and rom size
//////////////////////////////

`timescale 1ns/1ps
`include "md_core_macros.svh"

module cart_header_sniffer (
	input  logic                   clk_sys,
	input  logic                   arst_n,
	input  logic                   rom_download,
	input  logic                   rom_wr,
	input  md_cart_pkg::rom_addr_t rom_addr,
	input  md_cart_pkg::rom_word_t rom_data,
	output md_cart_pkg::cart_id_t  cart_id,
	output logic                   id_done,
	output md_cart_pkg::region_t   region,
	output logic                   export_region,
	output logic                   region_hold,
	output md_cart_pkg::rom_addr_t rom_size
);
	import md_cart_pkg::*;

	logic       dl_q;
	logic       dl_rise;
	logic       dl_fall;
	logic       hdr_wr;
	logic       hdr_ready;
	logic       hdr_ready_q;
	logic [2:0] rgn_flags; // {e, u, j}
	logic [2:0] rgn_next;
	logic [7:0] lo_byte;
	logic [7:0] hi_byte;
	logic [3:0] hrgn;

	// one-hot {e, u, j} for a region letter
	function automatic logic [2:0] letter_hit(input logic [7:0] c);
		case (c)
			"J":     return 3'b001;
			"U":     return 3'b010;
			"E":     return 3'b100;
			default: return 3'b000;
		endcase
	endfunction

	assign lo_byte = rom_data[7:0];
	assign hi_byte = rom_data[15:8];
	assign hrgn    = lo_byte[3:0] - 4'd7; // 'A'..'F' as hex digit
	assign hdr_wr  = rom_wr & rom_download;
	assign dl_rise = rom_download & ~dl_q;
	assign dl_fall = ~rom_download & dl_q;

	assign export_region = (region != REGION_JP);

	//////////////////////////////
	// region flags
	always_comb begin
		rgn_next = rgn_flags;
		if (hdr_wr && rom_addr == `MD_HDR_RGN0) begin
			if (letter_hit(lo_byte) != 3'b000)
				rgn_next = rgn_next | letter_hit(lo_byte);
			else if (lo_byte >= "0" && lo_byte <= "9")
				rgn_next = {lo_byte[3], lo_byte[2], lo_byte[0]};
			else if (lo_byte >= "A" && lo_byte <= "F")
				rgn_next = {hrgn[3], hrgn[2], hrgn[0]};
			rgn_next = rgn_next | letter_hit(hi_byte); // second letter slot
		end else if (hdr_wr && rom_addr == `MD_HDR_RGN1) begin
			rgn_next = rgn_next | letter_hit(lo_byte);
		end
	end

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			dl_q        <= 1'b0;
			rgn_flags   <= 3'b000;
			hdr_ready   <= 1'b0;
			hdr_ready_q <= 1'b0;
			region      <= REGION_US;
			region_hold <= 1'b0;
			rom_size    <= '0;
			id_done     <= 1'b0;
		end else begin
			dl_q        <= rom_download;
			hdr_ready_q <= hdr_ready;
			id_done     <= hdr_wr && (rom_addr == `MD_HDR_ID5); // id complete next cycle
			rgn_flags   <= dl_rise ? 3'b000 : rgn_next;

			if (hdr_wr && rom_addr == `MD_HDR_END)
				hdr_ready <= 1'b1;

			// pick region once the header is in, hold the core meanwhile
			if (hdr_ready && !hdr_ready_q) begin
				region_hold <= 1'b1;
				if (rgn_flags[1])      region <= REGION_US;
				else if (rgn_flags[2]) region <= REGION_EU;
				else if (rgn_flags[0]) region <= REGION_JP;
				else                   region <= REGION_US;
			end

			if (dl_fall) begin
				hdr_ready   <= 1'b0;
				region_hold <= 1'b0;
				rom_size    <= rom_addr; // last address of the image
			end
		end
	end

	//////////////////////////////
	// game id characters
	always_ff @(posedge clk_sys) begin
		if (hdr_wr) begin
			case (rom_addr)
				`MD_HDR_ID0: cart_id[63:56] <= hi_byte;
				`MD_HDR_ID1: cart_id[55:40] <= {lo_byte, hi_byte};
				`MD_HDR_ID2: cart_id[39:24] <= {lo_byte, hi_byte};
				`MD_HDR_ID3: cart_id[23:8]  <= {lo_byte, hi_byte};
				`MD_HDR_ID5: cart_id[7:0]   <= lo_byte;
				default: ;
			endcase
		end
	end

endmodule

// File: cart/cart_quirk_lookup.sv
//////////////////////////////
// game id table: compatibility quirk
// flags and light gun type and delay
//////////////////////////////

`timescale 1ns/1ps
`include "md_core_macros.svh"

module cart_quirk_lookup (
	input  logic                   clk_sys,
	input  logic                   arst_n,
	input  logic                   rom_download,
	input  md_cart_pkg::cart_id_t  cart_id,
	input  logic                   id_done,
	output md_cart_pkg::quirk_vec_t quirk_flags,
	output md_cart_pkg::gun_type_t gun_type,
	output logic [7:0]             gun_sensor_delay
);
	import md_cart_pkg::*;

	logic       dl_q;
	quirk_vec_t quirk_hit;
	gun_type_t  gun_next;
	logic [7:0] delay_next;

	// at most one flag per id
	function automatic quirk_vec_t quirk_match(input cart_id_t id);
		quirk_vec_t hit;
		hit = '0;
		case (id)
			"T-081276", "T-81406 ", "T-081586", "T-81576 ", "T-81476 ":
				hit[QK_SRAM] = 1'b1;
			"MK-1215 ", "G-4060  ", "00001211", "MK-1228 ", "G-5538  ",
			"00004076", "T-12046 ", "T-12053 ", "G-4524  ":
				hit[QK_EEPROM] = 1'b1;
			"T-113016": hit[QK_NORAM]  = 1'b1; // fake ram check
			"T-89016 ": hit[QK_FIFO]   = 1'b1;
			"T-574023", "T-574013":
				hit[QK_PIER] = 1'b1;
			"MK-1229 ", "G-7001  ":
				hit[QK_SVP] = 1'b1;          // dsp carts
			"T-35036 ", "T-25073 ", "MK-1137-":
				hit[QK_FMBUSY] = 1'b1;
			"T-68???-": hit[QK_SCHAN]  = 1'b1; // literal question marks
			" GM 0000": hit[QK_SRAM00] = 1'b1;
			default: ;
		endcase
		return hit;
	endfunction

	assign quirk_hit = quirk_match(cart_id);

	//////////////////////////////
	// light gun titles
	always_comb begin
		case (cart_id)
			"MK-1533 ": begin gun_next = GUN_MENACER;   delay_next = 8'd100; end
			"T-95096-": begin gun_next = GUN_JUSTIFIER; delay_next = 8'd52;  end
			"T-95136-": begin gun_next = GUN_JUSTIFIER; delay_next = 8'd30;  end
			"MK-1658 ": begin gun_next = GUN_MENACER;   delay_next = 8'd120; end
			"T-081156": begin gun_next = GUN_MENACER;   delay_next = 8'd126; end
			default: begin
				gun_next   = GUN_MENACER;
				delay_next = `MD_GUN_DELAY_DEF;
			end
		endcase
	end

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			dl_q             <= 1'b0;
			quirk_flags      <= '0;
			gun_type         <= GUN_MENACER;
			gun_sensor_delay <= `MD_GUN_DELAY_DEF;
		end else begin
			dl_q <= rom_download;
			if (rom_download && !dl_q)
				quirk_flags <= '0; // fresh image
			else if (id_done)
				quirk_flags <= quirk_flags | quirk_hit;

			if (id_done) begin
				gun_type         <= gun_next;
				gun_sensor_delay <= delay_next;
			end
		end
	end

endmodule

// File: common/md_bridge_pkg.sv
//////////////////////////////
// host bridge word type and the
// enums held by the settings registers
//////////////////////////////

package md_bridge_pkg;

	// one bridge transfer, address or data
	typedef logic [31:0] bridge_word_t;

	// cpu overclock setting, code 3 unused
	typedef enum logic [1:0] {
		TURBO_OFF  = 2'd0,
		TURBO_MID  = 2'd1,
		TURBO_HIGH = 2'd2
	} cpu_turbo_t;

	// audio low pass filter
	typedef enum logic [1:0] {
		LPF_OFF   = 2'd0,
		LPF_SOFT  = 2'd1,
		LPF_MID   = 2'd2,
		LPF_SHARP = 2'd3
	} lpf_mode_t;

endpackage

// File: common/md_cart_pkg.sv
//////////////////////////////
// cartridge side types: region, quirk
// flags, light gun, game id, rom and pads
//////////////////////////////

package md_cart_pkg;

	typedef enum logic [1:0] {
		REGION_JP = 2'd0,
		REGION_US = 2'd1,
		REGION_EU = 2'd2
	} region_t;

	// bit positions inside quirk_vec_t
	typedef enum logic [3:0] {
		QK_SRAM, QK_SRAM00, QK_EEPROM, QK_FIFO, QK_NORAM,
		QK_PIER, QK_SVP, QK_FMBUSY, QK_SCHAN
	} quirk_e;

	typedef logic [8:0] quirk_vec_t;

	typedef enum logic {
		GUN_MENACER   = 1'b0,
		GUN_JUSTIFIER = 1'b1
	} gun_type_t;

	typedef logic [63:0] cart_id_t;  // eight ascii chars, first in msb
	typedef logic [24:0] rom_addr_t; // byte address
	typedef logic [15:0] rom_word_t;
	typedef logic [15:0] pad_keys_t; // host key bitmap
	typedef logic [11:0] pad_word_t; // console pad word

endpackage

// File: common/md_core_macros.svh
//////////////////////////////
// bridge settings addresses, cartridge header
// word addresses, light gun default delay and
// pad synchronizer depth
//////////////////////////////

`ifndef MD_CORE_MACROS_SVH
`define MD_CORE_MACROS_SVH

// settings registers on the bridge
`define MD_ADDR_FILTER      32'h00F0_0000
`define MD_ADDR_FM_CHIP     32'h00A0_0000
`define MD_ADDR_TURBO       32'h00C0_0000
`define MD_ADDR_MULTITAP    32'h0000_0000
`define MD_ADDR_ASPECT      32'h0000_0010
`define MD_ADDR_COMPOSITE   32'h0000_0020
`define MD_ADDR_OBJ_LIMIT   32'h0000_0030
`define MD_ADDR_FM          32'h0000_0040
`define MD_ADDR_PSG         32'h0000_0050
`define MD_ADDR_HIFI_PCM    32'h0000_0060
`define MD_ADDR_LADDER      32'h0000_0070
`define MD_ADDR_REGION      32'h00E0_0000 // read only

// header byte addresses in the rom stream
`define MD_HDR_ID0          25'h182
`define MD_HDR_ID1          25'h184
`define MD_HDR_ID2          25'h186
`define MD_HDR_ID3          25'h188
`define MD_HDR_ID4          25'h18A
`define MD_HDR_ID5          25'h18C
`define MD_HDR_RGN0         25'h1F0
`define MD_HDR_RGN1         25'h1F2
`define MD_HDR_END          25'h200

`define MD_GUN_DELAY_DEF    8'd44
`define MD_SYNC_STAGES      3

`endif

// File: md_cart_core.f
+incdir+common
common/md_bridge_pkg.sv
common/md_cart_pkg.sv
cart/cart_header_sniffer.sv
cart/cart_quirk_lookup.sv
verilog/core_settings_regs.sv
verilog/pad_remap.sv
verilog/md_cart_core.sv
verification/tb_clock_gen.sv
verification/md_cart_core_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the md_cart_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module md_cart_core_tb \
	-f md_cart_core.f -Mdir obj_dir -o md_cart_core_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/md_cart_core_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -q "All checks passed"; then
	exit 0
fi
exit 1

// File: verification/md_cart_core_tb.sv
//////////////////////////////
// table driven testbench for md_cart_core:
// settings, header loads, quirks, pads
//////////////////////////////

`timescale 1ns/1ps
`include "md_core_macros.svh"

module md_cart_core_tb;
	import md_cart_pkg::*;

	localparam int NUM_ROWS  = 24;
	localparam int MAX_CYCLE = NUM_ROWS * 64 + 100;

	typedef enum logic [1:0] {K_BWR, K_BRD, K_HDR, K_PAD} kind_t;
	typedef struct packed {
		kind_t       kind;
		logic [31:0] addr;    // bridge address, or last rom address
		logic [63:0] data;    // write data, game id, or multitap state
		logic [23:0] rgn;     // {1f0 high, 1f0 low, 1f2 low}
		logic [11:0] exp_set;
		logic [31:0] exp;     // read data or region
		logic [8:0]  exp_q;
		logic        exp_gun;
		logic [7:0]  exp_dly;
	} row_t;

	logic clk_sys, arst_n;
	logic [31:0] bridge_addr, bridge_wr_data, bridge_rd_data;
	logic bridge_wr, rom_download, rom_wr, region_hold, export_region;
	rom_addr_t rom_addr, rom_size;
	rom_word_t rom_data;
	pad_keys_t cont1_key, cont2_key, cont3_key, cont4_key;
	pad_word_t pad1, pad2, pad3, pad4;
	quirk_vec_t quirk_flags;
	gun_type_t gun_type;
	logic [7:0] gun_sensor_delay;
	logic [1:0] cpu_turbo, lpf_mode;
	logic fm_chip, ar_correction, composite_en, obj_limit_high;
	logic fm_en, psg_en, hifi_pcm_en, ladder_en;

	row_t rows [NUM_ROWS];
	int n_rows = 0, n_checks = 0, n_errors = 0, cycles = 0;
	logic [15:0] lfsr = 16'd44230;

	tb_clock_gen u_clk (.clk_sys(clk_sys), .arst_n(arst_n));

	md_cart_core dut (.*);

	// run limit
	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLE) begin
			$display("Timeout: the run did not finish within %0d cycles", MAX_CYCLE);
			$display("Checks failed");
			$finish;
		end
	end

	task automatic add_row(input kind_t k, input logic [31:0] a, input logic [63:0] d,
			input logic [23:0] r, input logic [11:0] s, input logic [31:0] e,
			input logic [8:0] q, input logic g, input logic [7:0] dly);
		rows[n_rows] = '{k, a, d, r, s, e, q, g, dly};
		n_rows++;
	endtask

	// galois lfsr, one step per bit taken
	function automatic logic [15:0] random_word();
		logic [15:0] v;
		for (int i = 0; i < 16; i++) begin
			v[i] = lfsr[0];
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
		end
		return v;
	endfunction

	function automatic pad_word_t pad_expect(input pad_keys_t k);
		int order [12] = '{9, 6, 8, 14, 15, 4, 5, 7, 0, 1, 2, 3}; // Z Y X mode start B C A u d l r
		pad_word_t w;
		for (int i = 0; i < 12; i++)
			w[11-i] = k[order[i]];
		return w;
	endfunction

	function automatic logic [11:0] settings_now();
		return {cpu_turbo, lpf_mode, fm_chip, ar_correction, composite_en, obj_limit_high,
			fm_en, psg_en, hifi_pcm_en, ladder_en};
	endfunction

	task automatic note_error(input string what, input logic [63:0] got, input logic [63:0] exp);
		$display("Mismatch at %0t: %s got %0h expected %0h", $time, what, got, exp);
		n_errors++;
	endtask

	task automatic rom_write(input rom_addr_t a, input rom_word_t d);
		rom_addr = a;
		rom_data = d;
		rom_wr   = 1'b1;
		@(negedge clk_sys) rom_wr = 1'b0;
	endtask

	//////////////////////////////
	// one header load
	task automatic load_header(input row_t r);
		rom_download = 1'b1;
		@(negedge clk_sys);
		n_checks++;
		if (quirk_flags !== '0)
			note_error("flags after download start", 64'(quirk_flags), 0);
		rom_write(`MD_HDR_ID0, {r.data[63:56], 8'h20});
		rom_write(`MD_HDR_ID1, {r.data[47:40], r.data[55:48]});
		rom_write(`MD_HDR_ID2, {r.data[31:24], r.data[39:32]});
		rom_write(`MD_HDR_ID3, {r.data[15:8], r.data[23:16]});
		rom_write(`MD_HDR_ID4, 16'h2020);
		rom_write(`MD_HDR_ID5, {8'h20, r.data[7:0]});
		rom_write(`MD_HDR_RGN0, r.rgn[23:8]);
		rom_write(`MD_HDR_RGN1, {8'h20, r.rgn[7:0]});
		rom_write(`MD_HDR_END, 16'h0000);
		n_checks += 3;
		if (region_hold !== 1'b0)
			note_error("region_hold one cycle after end", 64'(region_hold), 0);
		rom_write(r.addr[24:0], 16'hFFFF);
		if (region_hold !== 1'b1)
			note_error("region_hold two cycles after end", 64'(region_hold), 1);
		rom_download = 1'b0;
		@(negedge clk_sys);
		if (region_hold !== 1'b0)
			note_error("region_hold after download", 64'(region_hold), 0);
		n_checks += 6;
		if (rom_size !== r.addr[24:0])
			note_error("rom_size", 64'(rom_size), 64'(r.addr[24:0]));
		if (quirk_flags !== r.exp_q)
			note_error("quirk_flags", 64'(quirk_flags), 64'(r.exp_q));
		if (gun_type !== r.exp_gun)
			note_error("gun_type", 64'(gun_type), 64'(r.exp_gun));
		if (gun_sensor_delay !== r.exp_dly)
			note_error("gun delay", 64'(gun_sensor_delay), 64'(r.exp_dly));
		bridge_addr = `MD_ADDR_REGION;
		@(negedge clk_sys);
		if (bridge_rd_data !== r.exp)
			note_error("region read", 64'(bridge_rd_data), 64'(r.exp));
		if (export_region !== (r.exp != 0))
			note_error("export_region", 64'(export_region), 64'(r.exp != 0));
	endtask

	task automatic pad_round(input logic tap_on);
		pad_keys_t k [4];
		for (int n = 0; n < 4; n++) begin
			for (int p = 0; p < 4; p++)
				k[p] = random_word();
			{cont1_key, cont2_key, cont3_key, cont4_key} = {k[0], k[1], k[2], k[3]};
			repeat (3) @(negedge clk_sys); // synchronizer depth
			n_checks += 4;
			if (pad1 !== pad_expect(k[0]))
				note_error("pad1", 64'(pad1), 64'(pad_expect(k[0])));
			if (pad2 !== pad_expect(k[1]))
				note_error("pad2", 64'(pad2), 64'(pad_expect(k[1])));
			if (pad3 !== (tap_on ? pad_expect(k[2]) : 12'h0))
				note_error("pad3", 64'(pad3), tap_on ? 64'(pad_expect(k[2])) : 64'd0);
			if (pad4 !== (tap_on ? pad_expect(k[3]) : 12'h0))
				note_error("pad4", 64'(pad4), tap_on ? 64'(pad_expect(k[3])) : 64'd0);
		end
	endtask

	initial begin
		int errs_before;
		{bridge_addr, bridge_wr_data, bridge_wr} = '0;
		{rom_download, rom_wr, rom_addr, rom_data} = '0;
		{cont1_key, cont2_key, cont3_key, cont4_key} = '0;

		//////////////////////////////
		// stimulus table
		add_row(K_BRD, 32'h10, 0, 0, 12'h01F, 0, 0, 0, 0);
		add_row(K_BWR, `MD_ADDR_FILTER,    3, 0, 12'h31F, 0, 0, 0, 0);
		add_row(K_BWR, `MD_ADDR_TURBO,     2, 0, 12'hB1F, 0, 0, 0, 0);
		add_row(K_BWR, `MD_ADDR_FM_CHIP,   1, 0, 12'hB9F, 0, 0, 0, 0);
		add_row(K_BWR, `MD_ADDR_ASPECT,    1, 0, 12'hBDF, 0, 0, 0, 0);
		add_row(K_BWR, `MD_ADDR_COMPOSITE, 1, 0, 12'hBFF, 0, 0, 0, 0);
		add_row(K_BWR, `MD_ADDR_OBJ_LIMIT, 0, 0, 12'hBEF, 0, 0, 0, 0);
		add_row(K_BWR, `MD_ADDR_FM,        0, 0, 12'hBE7, 0, 0, 0, 0);
		add_row(K_BWR, `MD_ADDR_PSG,       0, 0, 12'hBE3, 0, 0, 0, 0);
		add_row(K_BWR, `MD_ADDR_HIFI_PCM,  0, 0, 12'hBE1, 0, 0, 0, 0);
		add_row(K_BWR, `MD_ADDR_LADDER,    0, 0, 12'hBE0, 0, 0, 0, 0);
		add_row(K_BWR, 32'h80, 64'hFFFF_FFFF, 0, 12'hBE0, 0, 0, 0, 0);  // unmapped
		add_row(K_BWR, 32'h00F0_0004, 0, 0, 12'hBE0, 0, 0, 0, 0);
		add_row(K_PAD, 0, 0, 0, 0, 0, 0, 0, 0);
		add_row(K_BWR, `MD_ADDR_MULTITAP,  1, 0, 12'hBE0, 0, 0, 0, 0);
		add_row(K_PAD, 0, 1, 0, 0, 0, 0, 0, 0);
		add_row(K_HDR, 32'h3FFFE, "MK-1533 ", {" ", "J", " "}, 0, 0, 9'h000, 0, 100);
		add_row(K_HDR, 32'h7FFFE, "T-95096-", {" ", "U", " "}, 0, 1, 9'h000, 1, 52);
		add_row(K_HDR, 32'h0FFFE, "T-95136-", {" ", "E", " "}, 0, 2, 9'h000, 1, 30);
		add_row(K_HDR, 32'h1FFFE, "T-89016 ", {" ", "4", " "}, 0, 1, 9'h008, 0, 44);
		add_row(K_HDR, 32'h3FFFE, "MK-1229 ", {" ", "A", " "}, 0, 2, 9'h040, 0, 44);
		add_row(K_HDR, 32'h00FFE, "T-081156", {" ", " ", " "}, 0, 1, 9'h000, 0, 126);
		add_row(K_HDR, 32'h1FFFE, "ZZ-00000", {" ", "E", "J"}, 0, 2, 9'h000, 0, 44);
		add_row(K_HDR, 32'h0FFFE, "T-081276", {"U", "J", " "}, 0, 1, 9'h001, 0, 44);

		wait (arst_n === 1'b1);
		@(negedge clk_sys);
		for (int i = 0; i < n_rows; i++) begin
			errs_before = n_errors;
			case (rows[i].kind)
				K_BWR: begin
					bridge_addr    = rows[i].addr;
					bridge_wr_data = rows[i].data[31:0];
					bridge_wr      = 1'b1;
					@(negedge clk_sys) bridge_wr = 1'b0;
					n_checks++;
					if (settings_now() !== rows[i].exp_set)
						note_error("settings", 64'(settings_now()), 64'(rows[i].exp_set));
				end
				K_BRD: begin
					bridge_addr = rows[i].addr;
					@(negedge clk_sys);
					n_checks += 2;
					if (bridge_rd_data !== rows[i].exp)
						note_error("bridge read", 64'(bridge_rd_data), 64'(rows[i].exp));
					if (settings_now() !== rows[i].exp_set)
						note_error("settings", 64'(settings_now()), 64'(rows[i].exp_set));
				end
				K_HDR: load_header(rows[i]);
				default: pad_round(rows[i].data[0]);
			endcase
			if (n_errors == errs_before)
				$display("row %0d %s: ok", i, rows[i].kind.name());
			else
				$display("row %0d %s: FAIL", i, rows[i].kind.name());
		end

		$display("rows %0d, checks %0d, errors %0d", n_rows, n_checks, n_errors);
		if (n_errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

// File: verification/tb_clock_gen.sv
//////////////////////////////
// testbench clock, 40 ns period,
// and reset held for three cycles
//////////////////////////////

`timescale 1ns/1ps

module tb_clock_gen (
	output logic clk_sys,
	output logic arst_n
);
	initial begin
		clk_sys = 1'b0;
		forever #20 clk_sys = ~clk_sys;
	end

	initial begin
		arst_n = 1'b0;
		repeat (3) @(posedge clk_sys);
		@(negedge clk_sys) arst_n = 1'b1; // release away from the active edge
	end

endmodule

// File: verilog/core_settings_regs.sv
//////////////////////////////
// core settings registers written over
// the bridge, and the bridge read mux
//////////////////////////////

`timescale 1ns/1ps
`include "md_core_macros.svh"

module core_settings_regs (
	input  logic                        clk_sys,
	input  logic                        arst_n,
	input  md_bridge_pkg::bridge_word_t bridge_addr,
	input  logic                        bridge_wr,
	input  md_bridge_pkg::bridge_word_t bridge_wr_data,
	input  md_cart_pkg::region_t        region,
	output md_bridge_pkg::bridge_word_t bridge_rd_data,
	output md_bridge_pkg::cpu_turbo_t   cpu_turbo,
	output md_bridge_pkg::lpf_mode_t    lpf_mode,
	output logic                        fm_chip,
	output logic                        ar_correction,
	output logic                        composite_en,
	output logic                        obj_limit_high,
	output logic                        fm_en,
	output logic                        psg_en,
	output logic                        hifi_pcm_en,
	output logic                        ladder_en,
	output logic                        multitap_en
);
	import md_bridge_pkg::*;

	//////////////////////////////
	// write decode, exact addresses only
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			cpu_turbo      <= TURBO_OFF;
			lpf_mode       <= LPF_OFF;
			fm_chip        <= 1'b0;
			ar_correction  <= 1'b0;
			composite_en   <= 1'b0;
			multitap_en    <= 1'b0;
			obj_limit_high <= 1'b1;
			fm_en          <= 1'b1;
			psg_en         <= 1'b1;
			hifi_pcm_en    <= 1'b1;
			ladder_en      <= 1'b1;
		end else if (bridge_wr) begin
			case (bridge_addr)
				`MD_ADDR_FILTER:    lpf_mode       <= lpf_mode_t'(bridge_wr_data[1:0]);
				`MD_ADDR_TURBO:     cpu_turbo      <= cpu_turbo_t'(bridge_wr_data[1:0]);
				`MD_ADDR_FM_CHIP:   fm_chip        <= bridge_wr_data[0];
				`MD_ADDR_MULTITAP:  multitap_en    <= bridge_wr_data[0];
				`MD_ADDR_ASPECT:    ar_correction  <= bridge_wr_data[0];
				`MD_ADDR_COMPOSITE: composite_en   <= bridge_wr_data[0];
				`MD_ADDR_OBJ_LIMIT: obj_limit_high <= bridge_wr_data[0];
				`MD_ADDR_FM:        fm_en          <= bridge_wr_data[0];
				`MD_ADDR_PSG:       psg_en         <= bridge_wr_data[0];
				`MD_ADDR_HIFI_PCM:  hifi_pcm_en    <= bridge_wr_data[0];
				`MD_ADDR_LADDER:    ladder_en      <= bridge_wr_data[0];
				default: ; // unmapped, ignore
			endcase
		end
	end

	//////////////////////////////
	// read back, only the region is visible
	always_comb begin
		if (bridge_addr == `MD_ADDR_REGION)
			bridge_rd_data = {30'd0, region};
		else
			bridge_rd_data = '0;
	end

endmodule

// File: verilog/md_cart_core.sv
//////////////////////////////
// cartridge and configuration top:
// settings, header sniffer, quirks, pads
//////////////////////////////

`timescale 1ns/1ps

module md_cart_core (
	input  logic                        clk_sys,
	input  logic                        arst_n,
	// host bridge
	input  md_bridge_pkg::bridge_word_t bridge_addr,
	input  logic                        bridge_wr,
	input  md_bridge_pkg::bridge_word_t bridge_wr_data,
	output md_bridge_pkg::bridge_word_t bridge_rd_data,
	// rom load stream
	input  logic                        rom_download,
	input  logic                        rom_wr,
	input  md_cart_pkg::rom_addr_t      rom_addr,
	input  md_cart_pkg::rom_word_t      rom_data,
	// pads
	input  md_cart_pkg::pad_keys_t      cont1_key,
	input  md_cart_pkg::pad_keys_t      cont2_key,
	input  md_cart_pkg::pad_keys_t      cont3_key,
	input  md_cart_pkg::pad_keys_t      cont4_key,
	output md_cart_pkg::pad_word_t      pad1,
	output md_cart_pkg::pad_word_t      pad2,
	output md_cart_pkg::pad_word_t      pad3,
	output md_cart_pkg::pad_word_t      pad4,
	// cartridge results
	output md_cart_pkg::quirk_vec_t     quirk_flags,
	output md_cart_pkg::gun_type_t      gun_type,
	output logic [7:0]                  gun_sensor_delay,
	output md_cart_pkg::rom_addr_t      rom_size,
	output logic                        region_hold,
	output logic                        export_region,
	// settings
	output md_bridge_pkg::cpu_turbo_t   cpu_turbo,
	output md_bridge_pkg::lpf_mode_t    lpf_mode,
	output logic                        fm_chip,
	output logic                        ar_correction,
	output logic                        composite_en,
	output logic                        obj_limit_high,
	output logic                        fm_en,
	output logic                        psg_en,
	output logic                        hifi_pcm_en,
	output logic                        ladder_en
);
	import md_cart_pkg::*;

	region_t  cart_region;
	cart_id_t cart_id;
	logic     id_done;
	logic     multitap_en;

	core_settings_regs u_settings (
		.clk_sys        (clk_sys),
		.arst_n         (arst_n),
		.bridge_addr    (bridge_addr),
		.bridge_wr      (bridge_wr),
		.bridge_wr_data (bridge_wr_data),
		.region         (cart_region),
		.bridge_rd_data (bridge_rd_data),
		.cpu_turbo      (cpu_turbo),
		.lpf_mode       (lpf_mode),
		.fm_chip        (fm_chip),
		.ar_correction  (ar_correction),
		.composite_en   (composite_en),
		.obj_limit_high (obj_limit_high),
		.fm_en          (fm_en),
		.psg_en         (psg_en),
		.hifi_pcm_en    (hifi_pcm_en),
		.ladder_en      (ladder_en),
		.multitap_en    (multitap_en)
	);

	cart_header_sniffer u_sniffer (
		.clk_sys       (clk_sys),
		.arst_n        (arst_n),
		.rom_download  (rom_download),
		.rom_wr        (rom_wr),
		.rom_addr      (rom_addr),
		.rom_data      (rom_data),
		.cart_id       (cart_id),
		.id_done       (id_done),
		.region        (cart_region),
		.export_region (export_region),
		.region_hold   (region_hold),
		.rom_size      (rom_size)
	);

	cart_quirk_lookup u_quirks (
		.clk_sys          (clk_sys),
		.arst_n           (arst_n),
		.rom_download     (rom_download),
		.cart_id          (cart_id),
		.id_done          (id_done),
		.quirk_flags      (quirk_flags),
		.gun_type         (gun_type),
		.gun_sensor_delay (gun_sensor_delay)
	);

	pad_remap u_pads (
		.clk_sys     (clk_sys),
		.arst_n      (arst_n),
		.cont1_key   (cont1_key),
		.cont2_key   (cont2_key),
		.cont3_key   (cont3_key),
		.cont4_key   (cont4_key),
		.multitap_en (multitap_en),
		.pad1        (pad1),
		.pad2        (pad2),
		.pad3        (pad3),
		.pad4        (pad4)
	);

endmodule

// File: verilog/pad_remap.sv
//////////////////////////////
// pad key synchronizers, console button
// order and multitap gating
//////////////////////////////

`timescale 1ns/1ps
`include "md_core_macros.svh"

module pad_remap (
	input  logic                   clk_sys,
	input  logic                   arst_n,
	input  md_cart_pkg::pad_keys_t cont1_key,
	input  md_cart_pkg::pad_keys_t cont2_key,
	input  md_cart_pkg::pad_keys_t cont3_key,
	input  md_cart_pkg::pad_keys_t cont4_key,
	input  logic                   multitap_en,
	output md_cart_pkg::pad_word_t pad1,
	output md_cart_pkg::pad_word_t pad2,
	output md_cart_pkg::pad_word_t pad3,
	output md_cart_pkg::pad_word_t pad4
);
	import md_cart_pkg::*;

	pad_keys_t key_in   [4];
	pad_keys_t key_sync [4][`MD_SYNC_STAGES];
	pad_word_t pad_raw  [4];

	// Z Y X mode start B C A up down left right
	function automatic pad_word_t remap(input pad_keys_t k);
		return {k[9], k[6], k[8], k[14], k[15], k[4], k[5], k[7],
			k[0], k[1], k[2], k[3]};
	endfunction

	assign key_in[0] = cont1_key;
	assign key_in[1] = cont2_key;
	assign key_in[2] = cont3_key;
	assign key_in[3] = cont4_key;

	for (genvar p = 0; p < 4; p++) begin : g_pad
		always_ff @(posedge clk_sys or negedge arst_n) begin
			if (!arst_n) begin
				for (int s = 0; s < `MD_SYNC_STAGES; s++)
					key_sync[p][s] <= '0;
			end else begin
				key_sync[p][0] <= key_in[p]; // host side is async
				for (int s = 1; s < `MD_SYNC_STAGES; s++)
					key_sync[p][s] <= key_sync[p][s-1];
			end
		end

		assign pad_raw[p] = remap(key_sync[p][`MD_SYNC_STAGES-1]);
	end

	assign pad1 = pad_raw[0];
	assign pad2 = pad_raw[1];
	assign pad3 = multitap_en ? pad_raw[2] : '0; // only with the tap
	assign pad4 = multitap_en ? pad_raw[3] : '0;

endmodule
